// ==== project.f ====
+incdir+design
design/osdPkg.sv
design/spiOsdClient.sv
design/osdBuffer.sv
design/pixelClockEstimator.sv
design/syncAnalyzer.sv
design/osdCompositor.sv
design/osdOverlay.sv
testbench/osdOverlay_properties.sv
testbench/osdOverlay_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= osdOverlay_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) -f project.f --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG) || \
		! grep -q "TESTBENCH PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/osdOverlay_tb.sv ====
/* directed tests on an 800x300 source with active-low syncs; the window
   checks assume geometry has settled, which the passthrough test allows for */

`timescale 1ns/1ns
`default_nettype none

`include "osd_settings.svh"

module osdOverlay_tb;
	import osdPkg::*;

	localparam int lineLen   = 800;
	localparam int hsLen     = 96;
	localparam int frameLen  = 300;
	localparam int vsLen     = 2;
	localparam int frameCyc  = lineLen * frameLen;
	localparam int numTests  = 5;
	localparam int watchdogNs = numTests * 4 * frameCyc * 8 + 2_000_000;

	// window centred in the active area, counted from the first active pixel and line
	localparam int expFirstCol = ((lineLen - hsLen) - `OSD_WIDTH) / 2 + `OSD_X_OFFSET;
	localparam int expFirstLine = ((frameLen - vsLen) - `OSD_HEIGHT) / 2 + `OSD_Y_OFFSET;

	logic      clk_sys = 1'b0;
	logic      SPI_SCK = 1'b0;
	logic      SPI_SS3 = 1'b0;
	logic      SPI_DI  = 1'b0;
	videoBus_t videoIn = '0;
	videoBus_t videoOut;
	logic      osdShown;
	videoBus_t inHist = '0;
	logic [31:0] lcgState = 32'd76534;
	int        hPos = 0;
	int        vLine = 0;
	int        errors = 0;
	int        testsRun = 0;
	int        testsFailed = 0;

	osdOverlay dut_i (.*);

	bind osdCompositor osdOverlay_properties props_i (.*);

	initial begin
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		#(watchdogNs);
		$display("watchdog expired, the DUT did not finish the tests in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// ************************************************************
	// video source
	// ************************************************************

	always @(posedge clk_sys) begin
		videoBus_t nxt;
		lcgState <= lcgNext(lcgState);
		nxt.pix = lcgState[17:0];
		// low blue bits differ from the top ones so passthrough never looks overlaid
		nxt.pix.b[1:0] = ~lcgState[5:4];
		nxt.hSync = (hPos >= hsLen);
		nxt.vSync = (vLine >= vsLen);
		videoIn <= nxt;
		inHist <= videoIn;
		if (hPos == lineLen - 1) begin
			hPos <= 0;
			vLine <= (vLine == frameLen - 1) ? 0 : vLine + 1;
		end else begin
			hPos <= hPos + 1;
		end
	end

	// ************************************************************
	// SPI driver, SCK at a quarter of clk_sys
	// ************************************************************

	task automatic spiByte(input logic [7:0] b);
		for (int i = 7; i >= 0; i--) begin
			@(posedge clk_sys);
			SPI_SCK <= 1'b0;
			SPI_DI <= b[i];
			@(posedge clk_sys);
			@(posedge clk_sys);
			SPI_SCK <= 1'b1;
			@(posedge clk_sys);
		end
	endtask

	task automatic spiFrameEnd();
		@(posedge clk_sys);
		SPI_SCK <= 1'b0;
		SPI_SS3 <= 1'b1;
		repeat (4) @(posedge clk_sys);
		SPI_SS3 <= 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic writeBuffer(input logic [7:0] data);
		for (int line = 0; line < 8; line++) begin
			spiByte(8'h20 | 8'(line));
			repeat (256) spiByte(data);
			spiFrameEnd();
		end
	endtask

	task automatic waitShown(input string name, input logic level);
		int n;
		n = 0;
		while (osdShown !== level && n < 64) begin
			@(negedge clk_sys);
			n++;
		end
		if (osdShown !== level) begin
			$display("%s: osdShown did not reach %b within 64 cycles", name, level);
			errors++;
		end
	endtask

	function automatic logic isOverlay(videoBus_t o, videoBus_t i, logic [1:0] top);
		colour6_t tint;
		tint = `OSD_COLOR;
		return o.pix.r == {top, tint[5:4], i.pix.r[5:4]} &&
			o.pix.g == {top, tint[3:2], i.pix.g[5:4]} &&
			o.pix.b == {top, tint[1:0], i.pix.b[5:4]};
	endfunction

	// one full frame of output, from VSync rising to VSync falling
	task automatic measureFrame(input logic [1:0] top, output int nLines, output int firstLine,
			output int firstCol, output int badLines);
		logic prevH;
		logic prevV;
		int line;
		int col;
		int hits;
		int firstHit;
		int lastHit;
		nLines = 0;
		firstLine = -1;
		firstCol = -1;
		badLines = 0;
		line = -1;
		col = 0;
		hits = 0;
		firstHit = 0;
		lastHit = 0;
		prevV = 1'b1;
		@(negedge clk_sys);
		while (!(videoOut.vSync && !prevV)) begin
			prevV = videoOut.vSync;
			@(negedge clk_sys);
		end
		prevH = videoOut.hSync;
		prevV = 1'b1;
		while (!(prevV && !videoOut.vSync)) begin
			if (videoOut.hSync && !prevH) begin
				line++;
				col = 0;
				hits = 0;
			end
			if (line >= 0 && videoOut.hSync && isOverlay(videoOut, inHist, top)) begin
				if (hits == 0)
					firstHit = col;
				lastHit = col;
				hits++;
			end
			if (!videoOut.hSync && prevH && line >= 0 && hits > 0) begin
				nLines++;
				if (firstLine < 0) begin
					firstLine = line;
					firstCol = firstHit;
				end
				if (hits != `OSD_WIDTH || lastHit - firstHit + 1 != hits)
					badLines++;
				hits = 0;
			end
			col++;
			prevH = videoOut.hSync;
			prevV = videoOut.vSync;
			@(negedge clk_sys);
		end
	endtask

	task automatic checkValue(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("FAIL %s expected %0d actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic finishTest(input string name, input int errBefore);
		testsRun++;
		if (errors != errBefore) begin
			testsFailed++;
			$display("test %s: failed", name);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// ************************************************************
	// directed tests
	// ************************************************************

	task automatic testPassthrough();
		int e;
		e = errors;
		for (int n = 0; n < 2 * frameCyc; n++) begin
			@(negedge clk_sys);
			if (videoOut !== inHist) begin
				$display("FAIL passthrough expected %h actual %h", inHist, videoOut);
				errors++;
				break;
			end
			if (osdShown !== 1'b0) begin
				$display("passthrough: osdShown went high without an enable command");
				errors++;
				break;
			end
		end
		finishTest("passthrough", e);
	endtask

	task automatic testEnableDisable();
		int e;
		e = errors;
		spiByte(8'h41);
		spiFrameEnd();
		waitShown("enableDisable", 1'b1);
		spiByte(8'h40);
		spiFrameEnd();
		waitShown("enableDisable", 1'b0);
		finishTest("enableDisable", e);
	endtask

	task automatic windowTest(input string name, input logic [7:0] data, input logic [1:0] top);
		int e;
		int nLines;
		int firstLine;
		int firstCol;
		int badLines;
		e = errors;
		writeBuffer(data);
		spiByte(8'h41);
		spiFrameEnd();
		measureFrame(top, nLines, firstLine, firstCol, badLines);
		measureFrame(top, nLines, firstLine, firstCol, badLines);
		checkValue({name, " lines"}, `OSD_HEIGHT, nLines);
		checkValue({name, " bad lines"}, 0, badLines);
		finishTest(name, e);
	endtask

	task automatic testPlacement();
		int e;
		int nLines;
		int firstLine;
		int firstCol;
		int badLines;
		e = errors;
		measureFrame(2'b00, nLines, firstLine, firstCol, badLines);
		checkValue("placement column", expFirstCol, firstCol);
		checkValue("placement line", expFirstLine, firstLine);
		finishTest("placement", e);
	endtask

	initial begin
		@(posedge clk_sys);
		SPI_SS3 <= 1'b1;
		repeat (3) @(posedge clk_sys);
		SPI_SS3 <= 1'b0;
		testPassthrough();
		testEnableDisable();
		windowTest("litWindow", 8'hFF, 2'b11);
		windowTest("darkWindow", 8'h00, 2'b00);
		testPlacement();
		$display("tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== testbench/osdOverlay_properties.sv ====
/* bound into osdCompositor; checks hold from the second clock on */

`timescale 1ns/1ns
`default_nettype none

module osdOverlay_properties (
	input logic              clk_sys,
	input osdPkg::videoBus_t videoIn,
	input osdPkg::videoBus_t videoOut,
	input logic              osdEnable
);
	import osdPkg::*;

	logic pastValid = 1'b0;

	always_ff @(posedge clk_sys) begin
		pastValid <= 1'b1;
	end

	// syncs are delayed exactly one clock
	syncDelay: assert property (@(posedge clk_sys) disable iff (!pastValid)
		{videoOut.hSync, videoOut.vSync} == $past({videoIn.hSync, videoIn.vSync}))
		else $error("output syncs differ from the input syncs one cycle earlier");

	// no overlay while disabled
	colourPass: assert property (@(posedge clk_sys) disable iff (!pastValid)
		!$past(osdEnable) |-> videoOut.pix == $past(videoIn.pix))
		else $error("output colour changed while the overlay was disabled");

endmodule

`default_nettype wire

// ==== design/osdOverlay.sv ====
/* drop-in OSD stage for a 6-bit-per-channel VGA path; clk_sys should be
   locked to the core's pixel clock, SPI_SS3 only resets SPI framing */

`timescale 1ns/1ns
`default_nettype none

module osdOverlay (
	input  logic              clk_sys,
	input  logic              SPI_SCK,
	input  logic              SPI_SS3,
	input  logic              SPI_DI,
	input  osdPkg::videoBus_t videoIn,
	output osdPkg::videoBus_t videoOut,
	output logic              osdShown
);
	import osdPkg::*;

	logic       wrEn;
	bufAddr_t   wrAddr;
	logic [7:0] wrData;
	logic       osdEnable;
	bufAddr_t   rdAddr;
	logic [7:0] rdData;
	logic       pixEn;
	rasterPos_t pos;
	frameGeom_t geom;

	// ************************************************************
	// SPI side
	// ************************************************************

	spiOsdClient spiClient_i (
		.SPI_SCK  (SPI_SCK),
		.SPI_SS3  (SPI_SS3),
		.SPI_DI   (SPI_DI),
		.wrEn     (wrEn),
		.wrAddr   (wrAddr),
		.wrData   (wrData),
		.osdEnable(osdEnable)
	);

	osdBuffer buffer_i (
		.SPI_SCK(SPI_SCK),
		.wrEn   (wrEn),
		.wrAddr (wrAddr),
		.wrData (wrData),
		.clk_sys(clk_sys),
		.rdAddr (rdAddr),
		.rdData (rdData)
	);

	// ************************************************************
	// video side
	// ************************************************************

	pixelClockEstimator pixClock_i (
		.clk_sys(clk_sys),
		.hSync  (videoIn.hSync),
		.pixEn  (pixEn)
	);

	syncAnalyzer syncAnalyzer_i (
		.clk_sys(clk_sys),
		.pixEn  (pixEn),
		.hSync  (videoIn.hSync),
		.vSync  (videoIn.vSync),
		.pos    (pos),
		.geom   (geom)
	);

	osdCompositor compositor_i (
		.clk_sys  (clk_sys),
		.videoIn  (videoIn),
		.pos      (pos),
		.geom     (geom),
		.osdEnable(osdEnable),
		.rdAddr   (rdAddr),
		.rdData   (rdData),
		.videoOut (videoOut),
		.osdShown (osdShown)
	);

endmodule

`default_nettype wire

// ==== design/osdCompositor.sv ====
/* centres the 256x128 window in the measured active area, twice as tall
   under doublescan; every output is one clk_sys behind its input */

`timescale 1ns/1ns
`default_nettype none

`include "osd_settings.svh"

module osdCompositor (
	input  logic               clk_sys,
	input  osdPkg::videoBus_t  videoIn,
	input  osdPkg::rasterPos_t pos,
	input  osdPkg::frameGeom_t geom,
	input  logic               osdEnable,
	output osdPkg::bufAddr_t   rdAddr,
	input  logic [7:0]         rdData,
	output osdPkg::videoBus_t  videoOut,
	output logic               osdShown
);
	import osdPkg::*;

	localparam colour6_t osdTint = `OSD_COLOR;

	logic [9:0] winHeight;
	logic [9:0] hStart;
	logic [9:0] hEnd;
	logic [9:0] vStart;
	logic [9:0] vEnd;
	logic [9:0] winH;
	logic [9:0] winV;
	logic [9:0] winHAhead;
	logic [2:0] bitSel;
	logic       osdPixel;
	logic       hInside;
	logic       vInside;
	logic       osdActive;
	logic       shownReg = 1'b0;

	// pixel bit twice, tint pair, then the source's top bits
	function automatic colour6_t mixChannel(colour6_t src, logic [1:0] tint, logic pix);
		return {{2{pix}}, tint, src[5:4]};
	endfunction

	// ************************************************************
	// window placement
	// ************************************************************

	assign winHeight = 10'(`OSD_HEIGHT) << geom.doublescan;
	assign hStart = ((geom.dspWidth - 10'(`OSD_WIDTH)) >> 1) + 10'(`OSD_X_OFFSET);
	assign hEnd   = hStart + 10'(`OSD_WIDTH);
	assign vStart = ((geom.dspHeight - winHeight) >> 1) + 10'(`OSD_Y_OFFSET);
	assign vEnd   = vStart + winHeight;

	assign winH = pos.hCnt - hStart;
	assign winV = pos.vCnt - vStart;

	// address runs two pixels ahead to cover the registered address and read
	assign winHAhead = winH + 10'd2;

	assign hInside = (videoIn.hSync != geom.hsPol) && (pos.hCnt >= hStart) && (pos.hCnt < hEnd);
	assign vInside = (videoIn.vSync != geom.vsPol) && (pos.vCnt >= vStart) && (pos.vCnt < vEnd);
	assign osdActive = osdEnable && hInside && vInside;

	// ************************************************************
	// buffer access
	// ************************************************************

	// each byte is a column of eight pixel rows, 16 lines per group
	always_ff @(posedge clk_sys) begin
		rdAddr <= bufAddr_t'({geom.doublescan ? winV[7:5] : winV[6:4], winHAhead[7:0]});
	end

	assign bitSel   = geom.doublescan ? winV[4:2] : winV[3:1];
	assign osdPixel = rdData[bitSel];

	// ************************************************************
	// output stage
	// ************************************************************

	always_ff @(posedge clk_sys) begin
		videoOut.hSync <= videoIn.hSync;
		videoOut.vSync <= videoIn.vSync;
		if (osdActive) begin
			videoOut.pix.r <= mixChannel(videoIn.pix.r, osdTint[5:4], osdPixel);
			videoOut.pix.g <= mixChannel(videoIn.pix.g, osdTint[3:2], osdPixel);
			videoOut.pix.b <= mixChannel(videoIn.pix.b, osdTint[1:0], osdPixel);
		end else begin
			videoOut.pix <= videoIn.pix;
		end
		shownReg <= osdEnable;
	end

	assign osdShown = shownReg;

endmodule

`default_nettype wire

// ==== design/syncAnalyzer.sv ====
/* learns sync polarity and active size from the input itself; geometry
   settles after two full lines and two full frames */

`timescale 1ns/1ns
`default_nettype none

`include "osd_settings.svh"

module syncAnalyzer (
	input  logic               clk_sys,
	input  logic               pixEn,
	input  logic               hSync,
	input  logic               vSync,
	output osdPkg::rasterPos_t pos,
	output osdPkg::frameGeom_t geom
);

	logic       hsD    = 1'b0;
	logic       hsD2   = 1'b0;
	logic       vsD    = 1'b0;
	logic       vsD2   = 1'b0;
	logic [9:0] hCnt   = '0;
	logic [9:0] vCnt   = '0;
	logic [9:0] hsHigh = '0;
	logic [9:0] hsLow  = '0;
	logic [9:0] vsHigh = '0;
	logic [9:0] vsLow  = '0;

	assign pos = '{hCnt: hCnt, vCnt: vCnt};

	// ************************************************************
	// pixel-rate counters
	// ************************************************************

	always_ff @(posedge clk_sys) begin
		if (pixEn) begin
			hsD  <= hSync;
			hsD2 <= hsD;

			// hCnt restarts at 2 to make up for the two synchroniser stages
			if (!hsD && hsD2) begin
				hCnt   <= 10'd2;
				hsHigh <= hCnt - 10'd1;
			end else if (hsD && !hsD2) begin
				hCnt  <= 10'd2;
				hsLow <= hCnt - 10'd1;
				vCnt  <= vCnt + 10'd1;
			end else begin
				hCnt <= hCnt + 10'd1;
			end

			vsD  <= vSync;
			vsD2 <= vsD;

			// a VSync edge overrides the line step above
			// vCnt restarts one below zero so the first line of a level reads 0
			if (!vsD && vsD2) begin
				vCnt   <= '1;
				vsHigh <= vCnt + 10'd1;
			end else if (vsD && !vsD2) begin
				vCnt  <= '1;
				vsLow <= vCnt + 10'd1;
			end
		end
	end

	// ************************************************************
	// geometry
	// ************************************************************

	// the sync pulse is the shorter level, the active area the longer one
	always_ff @(posedge clk_sys) begin
		geom.hsPol      <= hsHigh < hsLow;
		geom.dspWidth   <= geom.hsPol ? hsLow : hsHigh;
		geom.vsPol      <= vsHigh < vsLow;
		geom.dspHeight  <= geom.vsPol ? vsLow : vsHigh;
		geom.doublescan <= geom.dspHeight > 10'(`DOUBLESCAN_LIMIT);
	end

endmodule

`default_nettype wire

// ==== design/pixelClockEstimator.sv ====
/* needs lines of 512 to 65535 clk_sys cycles; shorter lines give an enable
   on every cycle, the estimate assumes 512 to 1023 pixels per line */

`timescale 1ns/1ns
`default_nettype none

module pixelClockEstimator (
	input  logic clk_sys,
	input  logic hSync,
	output logic pixEn
);

	logic [15:0] lineCnt  = '0;
	logic [6:0]  pixSize  = '0;
	logic [6:0]  pixCnt   = '0;
	logic [6:0]  pixCntNext;
	logic        hsPrev   = 1'b0;
	logic        pixEnReg = 1'b0;

	assign pixCntNext = (pixCnt == pixSize) ? 7'd0 : pixCnt + 7'd1;
	assign pixEn = pixEnReg;

	always_ff @(posedge clk_sys) begin
		hsPrev <= hSync;

		// falling HSync restarts the pixel phase and takes a new divisor
		if (hsPrev && !hSync) begin
			lineCnt  <= '0;
			pixSize  <= (lineCnt[15:9] == 7'd0) ? 7'd0 : lineCnt[15:9] - 7'd1;
			pixCnt   <= '0;
			pixEnReg <= 1'b1;
		end else begin
			if (lineCnt != '1)
				lineCnt <= lineCnt + 16'd1;
			pixCnt   <= pixCntNext;
			pixEnReg <= (pixCntNext == 7'd0);
		end
	end

endmodule

`default_nettype wire

// ==== design/osdBuffer.sv ====
/* dual-clock display memory, no initial contents; read data appears one
   clk_sys cycle after rdAddr */

`timescale 1ns/1ns
`default_nettype none

`include "osd_settings.svh"

module osdBuffer (
	input  logic             SPI_SCK,
	input  logic             wrEn,
	input  osdPkg::bufAddr_t wrAddr,
	input  logic [7:0]       wrData,
	input  logic             clk_sys,
	input  osdPkg::bufAddr_t rdAddr,
	output logic [7:0]       rdData
);

	logic [7:0] mem [`OSD_BUF_DEPTH];

	// write port, SPI clock domain
	always_ff @(posedge SPI_SCK) begin
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

	// read port, video clock domain
	always_ff @(posedge clk_sys) begin
		rdData <= mem[rdAddr];
	end

endmodule

`default_nettype wire

// ==== design/spiOsdClient.sv ====
/* SPI mode 0 slave, MSB first; a write command fills one 256-byte line,
   the enable flag survives SPI_SS3 and powers up low */

`timescale 1ns/1ns
`default_nettype none

`include "osd_settings.svh"

module spiOsdClient (
	input  logic             SPI_SCK,
	input  logic             SPI_SS3,
	input  logic             SPI_DI,
	output logic             wrEn,
	output osdPkg::bufAddr_t wrAddr,
	output logic [7:0]       wrData,
	output logic             osdEnable
);
	import osdPkg::*;

	logic [3:0] bitCnt;
	logic [6:0] shiftReg;
	logic [7:0] rxByte;
	osdCmd_u    cmdNext;
	osdCmd_u    cmdReg;
	logic       enableReg = 1'b0;

	// byte completed by the bit sampled on this edge
	assign rxByte  = {shiftReg, SPI_DI};
	assign cmdNext = rxByte;

	// every byte after the command is payload
	assign wrEn   = (bitCnt == 4'd15) && (cmdReg.wr.op == `OSD_OP_WRITE);
	assign wrData = rxByte;

	assign osdEnable = enableReg;

	// ************************************************************
	// framing
	// ************************************************************

	// bits 0..7 are the command, then 8..15 repeat for each payload byte
	always_ff @(posedge SPI_SCK or posedge SPI_SS3) begin
		if (SPI_SS3) begin
			bitCnt <= '0;
			wrAddr <= '0;
		end else begin
			bitCnt <= (bitCnt == 4'd15) ? 4'd8 : bitCnt + 4'd1;
			if (bitCnt == 4'd7)
				wrAddr <= bufAddr_t'({cmdNext.wr.line, 8'h00});
			else if (wrEn)
				wrAddr <= wrAddr + bufAddr_t'(1);
		end
	end

	always_ff @(posedge SPI_SCK) begin
		shiftReg <= rxByte[6:0];
		if (bitCnt == 4'd7)
			cmdReg <= cmdNext;
	end

	// ************************************************************
	// enable / disable
	// ************************************************************

	always_ff @(posedge SPI_SCK) begin
		if (bitCnt == 4'd7 && cmdNext.en.op == `OSD_OP_ENABLE)
			enableReg <= cmdNext.en.enable;
	end

endmodule

`default_nettype wire

// ==== design/osdPkg.sv ====
/* types shared by the OSD blocks; the buffer address width follows
   OSD_BUF_DEPTH from the settings header */

`default_nettype none

`include "osd_settings.svh"

package osdPkg;

	typedef logic [5:0] colour6_t;

	typedef struct packed {
		colour6_t r;
		colour6_t g;
		colour6_t b;
	} rgbPixel_t;

	// one video sample on the VGA path
	typedef struct packed {
		rgbPixel_t pix;
		logic      hSync;
		logic      vSync;
	} videoBus_t;

	typedef struct packed {
		logic [9:0] dspWidth;
		logic [9:0] dspHeight;
		logic       hsPol;
		logic       vsPol;
		logic       doublescan;
	} frameGeom_t;

	typedef struct packed {
		logic [9:0] hCnt;
		logic [9:0] vCnt;
	} rasterPos_t;

	typedef logic [$clog2(`OSD_BUF_DEPTH)-1:0] bufAddr_t;

	// command byte, read as a line write or as enable/disable
	typedef struct packed {
		logic [4:0] op;
		logic [2:0] line;
	} writeCmd_t;

	typedef struct packed {
		logic [3:0] op;
		logic [2:0] spare;
		logic       enable;
	} enableCmd_t;

	typedef union packed {
		writeCmd_t  wr;
		enableCmd_t en;
	} osdCmd_u;

endpackage

`default_nettype wire

// ==== design/osd_settings.svh ====
/* window geometry, overlay colour and SPI opcodes; the offsets are signed
   and wrap inside the 10-bit raster counters */

`ifndef OSD_SETTINGS_SVH
`define OSD_SETTINGS_SVH

// window size in source pixels and lines
`define OSD_WIDTH         256
`define OSD_HEIGHT        128

// shift of the window away from the centre, negative moves left or up
`define OSD_X_OFFSET      0
`define OSD_Y_OFFSET      0

// two bits per channel, r in the top pair
`define OSD_COLOR         6'b111111

// eight lines of 256 bytes
`define OSD_BUF_DEPTH     2048

// command opcodes
`define OSD_OP_WRITE      5'b00100
`define OSD_OP_ENABLE     4'b0100

// taller displays are taken as line doubled
`define DOUBLESCAN_LIMIT  350

`endif
